// File: all.f
+incdir+rtl
rtl/round_pipe_pkg.sv
rtl/pipe_ctrl.sv
rtl/issue_unit.sv
rtl/round_stage.sv
rtl/retire_unit.sv
rtl/round_pipe_top.sv
testbench/tb_round_pipe.sv

// File: testbench/tb_round_pipe.sv
`timescale 1ns/100ps
`default_nettype none

`include "round_pipe_defs.svh"

module tb_round_pipe;

  localparam int N           = `RP_NUM_STAGES;
  localparam int CYCLE_LIMIT = 4000;

  logic                      clk;
  logic                      rst_i;
  logic                      flush_i;
  logic                      in_valid_i;
  round_pipe_pkg::op_word_u  in_op_i;
  logic [`RP_DATA_W-1:0]     in_acc_i;
  logic                      out_ready_i;
  logic                      in_ready_o;
  logic                      out_valid_o;
  logic [`RP_DATA_W-1:0]     out_acc_o;
  round_pipe_pkg::op_word_u  out_op_o;
  logic [31:0]               retired_count_o;

  // Expected results, oldest accepted item first
  logic [`RP_DATA_W-1:0]     exp_acc_q[$];
  round_pipe_pkg::op_word_u  exp_op_q[$];

  string                     test_name;
  // Sink behaviour: 0 never ready, 1 always ready, 2 random
  int                        sink_mode;
  int                        cycles;
  logic [`RP_DATA_W-1:0]     last_out_acc;
  int unsigned               seed_ret;

  round_pipe_top dut (
    .clk             (clk),
    .rst_i           (rst_i),
    .flush_i         (flush_i),
    .in_valid_i      (in_valid_i),
    .in_op_i         (in_op_i),
    .in_acc_i        (in_acc_i),
    .out_ready_i     (out_ready_i),
    .in_ready_o      (in_ready_o),
    .out_valid_o     (out_valid_o),
    .out_acc_o       (out_acc_o),
    .out_op_o        (out_op_o),
    .retired_count_o (retired_count_o)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Run length guard
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the pipeline did not finish within %0d cycles", CYCLE_LIMIT);
      $display("test failed");
      $fatal(1);
    end
  end

  // Consumer side, changes only on the falling edge
  always @(negedge clk) begin
    case (sink_mode)
      0:       out_ready_i = 1'b0;
      1:       out_ready_i = 1'b1;
      default: out_ready_i = 1'($urandom_range(0, 1));
    endcase
  end

  // Scoreboard, sees each edge with pre-edge values
  always @(posedge clk) begin
    if (!rst_i) begin
      // Full output and no ready must block the input
      if (out_valid_o && !out_ready_i) begin
        check_flag({test_name, " in_ready under stall"}, 1'b0, in_ready_o);
      end
      if (out_valid_o && out_ready_i) begin
        if (exp_acc_q.size() == 0) begin
          $display("%s: an output was delivered with no item expected", test_name);
          $display("test failed");
          $fatal(1);
        end else begin
          check_acc(test_name, exp_acc_q.pop_front(), out_acc_o);
          check_op(test_name, exp_op_q.pop_front(), out_op_o);
          last_out_acc = out_acc_o;
        end
      end
      // Everything in flight is dropped, a same-edge transfer still counts
      if (flush_i) begin
        exp_acc_q.delete();
        exp_op_q.delete();
      end
      if (in_valid_i && in_ready_o) begin
        exp_acc_q.push_back(rounds_applied(in_op_i, in_acc_i));
        exp_op_q.push_back(in_op_i);
      end
    end
  end

  // Model: instruction applied once per stage
  function automatic logic [31:0] rounds_applied(logic [31:0] word, logic [31:0] acc);
    logic [31:0] a;
    logic [31:0] imm;
    int unsigned sh;
    a   = acc;
    imm = {2'b00, word[29:0]};
    sh  = word[4:0];
    for (int i = 0; i < N; i++) begin
      case (word[31:30])
        2'd0:    a = a + imm;
        2'd1:    a = a ^ imm;
        // Shift by 32 gives zero, so amount 0 keeps the value
        2'd2:    a = (a << sh) | (a >> (32 - sh));
        default: a = a;
      endcase
    end
    return a;
  endfunction

  function automatic logic [31:0] random_word(logic [1:0] opc);
    logic [29:0] body;
    body = 30'($urandom);
    return {opc, body};
  endfunction

  task automatic check_acc(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL %s acc expected %h actual %h", name, exp, act);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic check_op(string name, round_pipe_pkg::op_word_u exp,
                          round_pipe_pkg::op_word_u act);
    if (exp !== act) begin
      $display("FAIL %s op expected %h actual %h", name, exp, act);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic check_count(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL %s count expected %0d actual %0d", name, exp, act);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("FAIL %s expected %b actual %b", name, exp, act);
      $display("test failed");
      $fatal(1);
    end
  endtask

  // Mode changes on the rising edge, sink reads it on the falling one
  task automatic set_sink(int mode);
    @(posedge clk);
    sink_mode = mode;
  endtask

  // Offer one item and hold it until the edge that takes it
  task automatic send_item(logic [31:0] word, logic [31:0] acc);
    @(negedge clk);
    in_valid_i = 1'b1;
    in_op_i    = round_pipe_pkg::op_word_u'(word);
    in_acc_i   = acc;
    @(posedge clk);
    while (!in_ready_o) begin
      @(posedge clk);
    end
  endtask

  task automatic stop_input();
    @(negedge clk);
    in_valid_i = 1'b0;
  endtask

  // Wait until every accepted item has come out
  task automatic drain();
    @(negedge clk);
    while (exp_acc_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic reset_dut();
    rst_i = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    check_flag("reset out_valid", 1'b0, out_valid_o);
    check_count("reset count", 32'd0, retired_count_o);
    @(negedge clk);
    check_flag("reset in_ready", 1'b1, in_ready_o);
  endtask

  task automatic single_latency_test();
    logic [31:0] word;
    logic [31:0] acc;
    int          edges;
    test_name = "single_latency";
    set_sink(1);
    word = {2'b00, 30'h0123_4567};
    // Wraps past 2^32
    acc  = 32'hffff_fff0;
    send_item(word, acc);
    // Acceptance edge loads the issue register, count it as the first
    edges = 1;
    @(negedge clk);
    in_valid_i = 1'b0;
    while (!out_valid_o) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    // Issue, N stages, retire
    check_count("single_latency edges", N + 2, edges);
    check_acc(test_name, acc + 32'(word[29:0]) * N, out_acc_o);
    drain();
    check_count(test_name, 32'd1, retired_count_o);
  endtask

  task automatic union_decode_test();
    logic [31:0] word;
    logic [31:0] acc;
    logic [31:0] base;
    logic [1:0]  opc;
    test_name = "union_decode";
    set_sink(1);
    @(negedge clk);
    base = retired_count_o;
    // First four items cover every opcode, reserved one included
    for (int i = 0; i < 40; i++) begin
      opc = (i < 4) ? 2'(i) : 2'($urandom_range(0, 3));
      send_item(random_word(opc), $urandom);
    end
    stop_input();
    drain();
    check_count(test_name, base + 40, retired_count_o);
    // XOR twice cancels out
    test_name = "xor_rounds";
    word = random_word(2'd1);
    acc  = $urandom;
    send_item(word, acc);
    stop_input();
    drain();
    check_acc(test_name, (N % 2 == 0) ? acc : acc ^ {2'b00, word[29:0]}, last_out_acc);
  endtask

  task automatic back_pressure_test();
    logic [31:0] base;
    test_name = "back_pressure";
    set_sink(2);
    @(negedge clk);
    base = retired_count_o;
    for (int i = 0; i < 40; i++) begin
      send_item(random_word(2'($urandom_range(0, 3))), $urandom);
    end
    stop_input();
    set_sink(1);
    drain();
    check_count(test_name, base + 40, retired_count_o);
  endtask

  task automatic flush_test();
    logic [31:0] base;
    test_name = "flush";
    set_sink(1);
    @(negedge clk);
    base = retired_count_o;
    // Three items still inside the stages when flushed
    for (int i = 0; i < 3; i++) begin
      send_item(random_word(2'd0), $urandom);
    end
    @(negedge clk);
    in_valid_i = 1'b0;
    flush_i    = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
    // Scoreboard rejects any output in this window
    repeat (N + 4) @(negedge clk);
    check_count(test_name, base, retired_count_o);
    // Flush beats a stalled, full output
    set_sink(0);
    send_item(random_word(2'd1), $urandom);
    send_item(random_word(2'd2), $urandom);
    stop_input();
    while (!out_valid_o) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
    flush_i = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
    check_flag("flush stalled out_valid", 1'b0, out_valid_o);
    set_sink(1);
    repeat (N + 4) @(negedge clk);
    check_count(test_name, base, retired_count_o);
    // Later items are unaffected
    for (int i = 0; i < 4; i++) begin
      send_item(random_word(2'($urandom_range(0, 3))), $urandom);
    end
    stop_input();
    drain();
    check_count(test_name, base + 4, retired_count_o);
  endtask

  task automatic bubble_test();
    logic [31:0] base;
    int          gap;
    test_name = "bubbles";
    set_sink(1);
    @(negedge clk);
    base = retired_count_o;
    for (int i = 0; i < 30; i++) begin
      send_item(random_word(2'($urandom_range(0, 3))), $urandom);
      gap = $urandom_range(0, 3);
      // gap idle cycles before the next offer
      if (gap > 0) begin
        @(negedge clk);
        in_valid_i = 1'b0;
        repeat (gap - 1) @(negedge clk);
      end
    end
    stop_input();
    drain();
    check_count(test_name, base + 30, retired_count_o);
  endtask

  initial begin
    seed_ret     = $urandom(32'h5407_a7e3);
    rst_i        = 1'b1;
    flush_i      = 1'b0;
    in_valid_i   = 1'b0;
    in_op_i      = '0;
    in_acc_i     = '0;
    out_ready_i  = 1'b0;
    sink_mode    = 1;
    cycles       = 0;
    last_out_acc = '0;
    test_name    = "reset";
    reset_dut();
    single_latency_test();
    union_decode_test();
    back_pressure_test();
    flush_test();
    bubble_test();
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/round_pipe_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "round_pipe_defs.svh"

module round_pipe_top (
  input  wire logic                       clk,
  input  wire logic                       rst_i,
  input  wire logic                       flush_i,
  input  wire logic                       in_valid_i,
  input  wire round_pipe_pkg::op_word_u   in_op_i,
  input  wire logic [`RP_DATA_W-1:0]      in_acc_i,
  input  wire logic                       out_ready_i,
  output logic                            in_ready_o,
  output logic                            out_valid_o,
  output logic [`RP_DATA_W-1:0]           out_acc_o,
  output round_pipe_pkg::op_word_u        out_op_o,
  output logic [31:0]                     retired_count_o
);

  localparam int N = `RP_NUM_STAGES;

  // Boundary controls: 0 issue, 1..N stages, N+1 retire
  logic [N+1:0] advance;
  logic [N+1:0] bubble;
  logic [N+1:0] flush;
  logic         stall;
  logic         up_valid;

  // Item chain, index k feeds stage k; index N goes to retire
  logic                     chain_valid   [0:N];
  round_pipe_pkg::opcode_e  chain_opcode  [0:N];
  round_pipe_pkg::operand_t chain_operand [0:N];
  logic [`RP_DATA_W-1:0]    chain_acc     [0:N];
  round_pipe_pkg::op_word_u chain_op      [0:N];

  pipe_ctrl u_ctrl (
    .rst_i      (rst_i),
    .clk        (clk),
    .stall_i    (stall),
    .flush_i    (flush_i),
    .up_valid_i (up_valid),
    .advance_o  (advance),
    .bubble_o   (bubble),
    .flush_o    (flush),
    .in_ready_o (in_ready_o)
  );

  issue_unit u_issue (
    .clk (clk), .rst_i (rst_i),
    .in_valid_i   (in_valid_i),   .in_op_i     (in_op_i),     .in_acc_i (in_acc_i),
    .advance_i    (advance[0]),   .bubble_i    (bubble[0]),   .flush_i  (flush[0]),
    .in_ready_i   (in_ready_o),   .up_valid_o  (up_valid),
    .s0_valid_o   (chain_valid[0]),   .s0_opcode_o (chain_opcode[0]),
    .s0_operand_o (chain_operand[0]), .s0_acc_o    (chain_acc[0]),
    .s0_op_o      (chain_op[0])
  );

  // Identical round stages
  for (genvar k = 0; k < N; k++) begin : g_stage
    round_stage u_stage (
      .clk (clk), .rst_i (rst_i),
      .advance_i      (advance[k+1]),     .bubble_i   (bubble[k+1]),
      .flush_i        (flush[k+1]),       .prev_valid_i (chain_valid[k]),
      .prev_opcode_i  (chain_opcode[k]),  .prev_operand_i (chain_operand[k]),
      .prev_acc_i     (chain_acc[k]),     .prev_op_i  (chain_op[k]),
      .valid_o        (chain_valid[k+1]), .opcode_o   (chain_opcode[k+1]),
      .operand_o      (chain_operand[k+1]), .acc_o    (chain_acc[k+1]),
      .op_o           (chain_op[k+1])
    );
  end

  retire_unit u_retire (
    .clk (clk), .rst_i (rst_i),
    .advance_i    (advance[N+1]),  .bubble_i    (bubble[N+1]),  .flush_i (flush[N+1]),
    .last_valid_i (chain_valid[N]), .last_acc_i (chain_acc[N]), .last_op_i (chain_op[N]),
    .out_ready_i  (out_ready_i),   .out_valid_o (out_valid_o),
    .out_acc_o    (out_acc_o),     .out_op_o    (out_op_o),
    .stall_o      (stall),         .retired_count_o (retired_count_o)
  );

endmodule

`default_nettype wire

// File: rtl/retire_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "round_pipe_defs.svh"

module retire_unit (
  input  wire logic                       clk,
  input  wire logic                       rst_i,
  input  wire logic                       advance_i,
  input  wire logic                       bubble_i,
  input  wire logic                       flush_i,
  input  wire logic                       last_valid_i,
  input  wire logic [`RP_DATA_W-1:0]      last_acc_i,
  input  wire round_pipe_pkg::op_word_u   last_op_i,
  input  wire logic                       out_ready_i,
  output logic                            out_valid_o,
  output logic [`RP_DATA_W-1:0]           out_acc_o,
  output round_pipe_pkg::op_word_u        out_op_o,
  output logic                            stall_o,
  output logic [31:0]                     retired_count_o
);

  logic out_xfer;

  // Consumer takes the held item this cycle
  assign out_xfer = out_valid_o && out_ready_i;

  // Full and blocked, the whole pipe must hold
  assign stall_o = out_valid_o && !out_ready_i;

  // Output valid
  // A transfer frees the slot and the same edge refills it on advance
  always_ff @(posedge clk) begin
    if (rst_i || flush_i || bubble_i) begin
      out_valid_o <= 1'b0;
    end else if (advance_i) begin
      out_valid_o <= last_valid_i;
    end
  end

  // Finished item data
  always_ff @(posedge clk) begin
    if (advance_i && last_valid_i) begin
      out_acc_o <= last_acc_i;
      out_op_o  <= last_op_i;
    end
  end

  // Counts handshakes on the output port
  always_ff @(posedge clk) begin
    if (rst_i) begin
      retired_count_o <= '0;
    end else if (out_xfer) begin
      retired_count_o <= retired_count_o + 32'd1;
    end
  end

  // Held item must not change while the sink is not ready
  a_out_stable: assert property (@(posedge clk) disable iff (rst_i)
    out_valid_o && !out_ready_i && !flush_i |=>
      out_valid_o && $stable(out_acc_o) && $stable(out_op_o));

endmodule

`default_nettype wire

// File: rtl/round_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "round_pipe_defs.svh"

module round_stage (
  input  wire logic                       clk,
  input  wire logic                       rst_i,
  input  wire logic                       advance_i,
  input  wire logic                       bubble_i,
  input  wire logic                       flush_i,
  input  wire logic                       prev_valid_i,
  input  wire round_pipe_pkg::opcode_e    prev_opcode_i,
  input  wire round_pipe_pkg::operand_t   prev_operand_i,
  input  wire logic [`RP_DATA_W-1:0]      prev_acc_i,
  input  wire round_pipe_pkg::op_word_u   prev_op_i,
  output logic                            valid_o,
  output round_pipe_pkg::opcode_e         opcode_o,
  output round_pipe_pkg::operand_t        operand_o,
  output logic [`RP_DATA_W-1:0]           acc_o,
  output round_pipe_pkg::op_word_u        op_o
);

  logic [`RP_ROT_W-1:0]     rot_amt;
  logic [2*`RP_DATA_W-1:0]  rot_wide;
  logic [`RP_DATA_W-1:0]    next_acc;

  // Rotate amount lives in the low operand bits
  assign rot_amt = prev_operand_i[`RP_ROT_W-1:0];

  // Doubled word shifted left, upper half is the rotated value
  assign rot_wide = {prev_acc_i, prev_acc_i} << rot_amt;

  // One application of the instruction
  always_comb begin
    case (prev_opcode_i)
      round_pipe_pkg::OP_ADD: begin
        // Wraps modulo 2^32
        next_acc = prev_acc_i + prev_operand_i;
      end
      round_pipe_pkg::OP_XOR: begin
        next_acc = prev_acc_i ^ prev_operand_i;
      end
      round_pipe_pkg::OP_ROL: begin
        next_acc = rot_wide[2*`RP_DATA_W-1:`RP_DATA_W];
      end
      default: begin
        // Reserved opcode passes through
        next_acc = prev_acc_i;
      end
    endcase
  end

  // Valid follows upstream on advance, so bubbles move along too
  always_ff @(posedge clk) begin
    if (rst_i || flush_i || bubble_i) begin
      valid_o <= 1'b0;
    end else if (advance_i) begin
      valid_o <= prev_valid_i;
    end
  end

  // Payload only changes for a real item
  always_ff @(posedge clk) begin
    if (advance_i && prev_valid_i) begin
      opcode_o  <= prev_opcode_i;
      operand_o <= prev_operand_i;
      acc_o     <= next_acc;
      op_o      <= prev_op_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/issue_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "round_pipe_defs.svh"

module issue_unit (
  input  wire logic                       clk,
  input  wire logic                       rst_i,
  input  wire logic                       in_valid_i,
  input  wire round_pipe_pkg::op_word_u   in_op_i,
  input  wire logic [`RP_DATA_W-1:0]      in_acc_i,
  input  wire logic                       advance_i,
  input  wire logic                       bubble_i,
  input  wire logic                       flush_i,
  input  wire logic                       in_ready_i,
  output logic                            up_valid_o,
  output logic                            s0_valid_o,
  output round_pipe_pkg::opcode_e         s0_opcode_o,
  output round_pipe_pkg::operand_t        s0_operand_o,
  output logic [`RP_DATA_W-1:0]           s0_acc_o,
  output round_pipe_pkg::op_word_u        s0_op_o
);

  round_pipe_pkg::opcode_e  dec_opcode;
  round_pipe_pkg::operand_t dec_operand;

  // Request toward control only when the transfer actually happens
  assign up_valid_o = in_valid_i && in_ready_i;

  // Single decode point; stages see opcode and operand only
  always_comb begin
    dec_opcode = in_op_i.imm.opcode;
    if (dec_opcode == round_pipe_pkg::OP_ROL) begin
      // Rotate view, amount zero extended
      dec_operand = round_pipe_pkg::operand_t'(in_op_i.rot.amount);
    end else begin
      // Immediate view, also used for the reserved opcode
      dec_operand = round_pipe_pkg::operand_t'(in_op_i.imm.imm);
    end
  end

  // Stage-0 valid
  always_ff @(posedge clk) begin
    if (rst_i || flush_i || bubble_i) begin
      s0_valid_o <= 1'b0;
    end else if (advance_i) begin
      s0_valid_o <= 1'b1;
    end
  end

  // Payload loads only on an accepted item
  always_ff @(posedge clk) begin
    if (advance_i) begin
      s0_opcode_o  <= dec_opcode;
      s0_operand_o <= dec_operand;
      s0_acc_o     <= in_acc_i;
      s0_op_o      <= in_op_i;
    end
  end

  // Source keeps its offer steady until it is taken
  a_in_stable: assert property (@(posedge clk) disable iff (rst_i)
    in_valid_i && !in_ready_i |=> in_valid_i && $stable(in_op_i) && $stable(in_acc_i));

endmodule

`default_nettype wire

// File: rtl/pipe_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "round_pipe_defs.svh"

module pipe_ctrl (
  input  wire logic                      rst_i,
  input  wire logic                      clk,
  input  wire logic                      stall_i,
  input  wire logic                      flush_i,
  input  wire logic                      up_valid_i,
  output logic [`RP_NUM_STAGES+1:0]      advance_o,
  output logic [`RP_NUM_STAGES+1:0]      bubble_o,
  output logic [`RP_NUM_STAGES+1:0]      flush_o,
  output logic                           in_ready_o
);

  // Boundary 0 is issue, 1..N the stages, N+1 retire
  localparam int NUM_BOUND = `RP_NUM_STAGES + 2;

  // Per boundary bubble request
  // Only the issue boundary asks; inner bubbles just flow downstream
  logic [NUM_BOUND-1:0] bubble_req;

  always_comb begin
    bubble_req    = '0;
    bubble_req[0] = !up_valid_i;
  end

  // Priority: flush, then bubble, then advance, else hold
  always_comb begin
    for (int i = 0; i < NUM_BOUND; i++) begin
      flush_o[i]   = flush_i;
      bubble_o[i]  = !stall_i && bubble_req[i] && !flush_i;
      advance_o[i] = !stall_i && !bubble_req[i] && !flush_i;
    end
  end

  // No input accepted while stalled or flushing
  assign in_ready_o = !stall_i && !flush_i;

  // Never two actions on one boundary
  a_ctrl_exclusive: assert property (@(posedge clk) disable iff (rst_i)
    ((advance_o & bubble_o) | (advance_o & flush_o) | (bubble_o & flush_o)) == '0);

  // A stalled pipe neither loads nor drops anything
  a_stall_holds: assert property (@(posedge clk) disable iff (rst_i)
    stall_i |-> ((advance_o | bubble_o) == '0) && !in_ready_o);

  // Flush reaches every register, retire included
  a_flush_all: assert property (@(posedge clk) disable iff (rst_i)
    flush_i |-> (&flush_o) && !in_ready_o);

endmodule

`default_nettype wire

// File: rtl/round_pipe_pkg.sv
`default_nettype none

`include "round_pipe_defs.svh"

package round_pipe_pkg;

  // Opcode in the top bits of every operation word
  // Value 3 is reserved and leaves the accumulator unchanged
  typedef enum logic [`RP_OPC_W-1:0] {
    OP_ADD = 2'd0,
    OP_XOR = 2'd1,
    OP_ROL = 2'd2
  } opcode_e;

  // Immediate form, used by ADD and XOR
  typedef struct packed {
    opcode_e                          opcode;
    logic [`RP_OP_W-`RP_OPC_W-1:0]    imm;
  } op_imm_t;

  // Rotate form, amount sits in the low bits
  typedef struct packed {
    opcode_e                                   opcode;
    logic [`RP_OP_W-`RP_OPC_W-`RP_ROT_W-1:0]   unused;
    logic [`RP_ROT_W-1:0]                      amount;
  } op_rot_t;

  // Same word, two decodes; opcode position is shared
  typedef union packed {
    op_imm_t imm;
    op_rot_t rot;
  } op_word_u;

  // Decoded operand carried with each item through the stages
  typedef logic [`RP_DATA_W-1:0] operand_t;

endpackage

`default_nettype wire

// File: rtl/round_pipe_defs.svh
`ifndef ROUND_PIPE_DEFS_SVH
`define ROUND_PIPE_DEFS_SVH

// Number of identical round stages, any value of 1 or more
`define RP_NUM_STAGES 4

// Accumulator and decoded operand width
`define RP_DATA_W 32

// Full operation word width
`define RP_OP_W 32

// Opcode field width, top bits of the operation word
`define RP_OPC_W 2

// Rotate amount field width, low bits of the operation word
`define RP_ROT_W 5

`endif
